// File: axi_burst_master.f
logic/burst_pkg.sv
logic/beat_counter.sv
logic/write_cmd_planner.sv
logic/write_ctrl_fsm.sv
logic/read_channel.sv
logic/axi_burst_master.sv
tests/axi_burst_master_props.sv
tests/axi_burst_master_tb.sv

// File: Makefile
# Verilator flow for the AXI4 burst master testbench

VERILATOR ?= verilator
TOP       ?= axi_burst_master_tb
FILELIST  ?= axi_burst_master.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= ** PASS **

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// File: tests/axi_burst_master_tb.sv
// testbench for the AXI4 burst master, random commands against an AXI slave model and a reference model
`timescale 1ns/1ps
`default_nettype none

module axi_burst_master_tb
    import burst_pkg::*;
;

    localparam int        N_CMDS     = 40;
    localparam int        MAX_BEATS  = 64;
    localparam int        CLK_HALF   = 10;
    localparam int        TIMEOUT_NS = 2 * N_CMDS * (MAX_BEATS * 8 + 100) * 2 * CLK_HALF;
    localparam bit [15:0] SEED       = 16'd21613;

    logic     aclk = 1'b0;
    logic     aresetn;
    addr_t    m_axi_awaddr;
    len_t     m_axi_awlen;
    logic     m_axi_awvalid;
    logic     m_axi_awready = 1'b0;
    data_t    m_axi_wdata;
    strb_t    m_axi_wstrb;
    logic     m_axi_wvalid;
    logic     m_axi_wlast;
    logic     m_axi_wready = 1'b0;
    resp_t    m_axi_bresp = '0;
    logic     m_axi_bvalid = 1'b0;
    logic     m_axi_bready;
    addr_t    m_axi_araddr;
    len_t     m_axi_arlen;
    logic     m_axi_arvalid;
    logic     m_axi_arready = 1'b0;
    data_t    m_axi_rdata = '0;
    resp_t    m_axi_rresp = '0;
    logic     m_axi_rvalid = 1'b0;
    logic     m_axi_rlast = 1'b0;
    logic     m_axi_rready;
    logic     user_w_start;
    addr_t    user_w_addr;
    len_t     user_w_len;
    data_t    user_w_data = '0;
    strb_t    user_w_strb;
    beats_t   user_w_fifo_cnt = '0;
    logic     user_w_data_pop_req;
    logic     user_w_free;
    resp_t    user_w_status;
    cmd_err_t user_w_cmd_error;
    logic     user_r_start;
    addr_t    user_r_addr;
    len_t     user_r_len;
    logic     user_r_fifo_full = 1'b0;
    data_t    user_r_data;
    logic     user_r_data_push_req;
    logic     user_r_free;
    resp_t    user_r_status;

    logic [15:0] lfsr_q = SEED;
    int          value_errors = 0;
    int          other_errors = 0;

    // write side model state
    data_t  wfifo[$];      // user write FIFO contents
    data_t  exp_wdata[$];  // beats the W channel must carry, in order
    burst_t exp_aw[$];
    burst_t aw_want;
    len_t   cur_wlen = '0;
    int     wbeat_idx = 0;
    int     pop_count = 0;
    int     b_pending = 0;
    resp_t  last_bresp = '0;
    logic   pop_seen = 1'b0;
    logic   b_hs = 1'b0;

    // read side model state
    logic  slave_live = 1'b0;
    logic  r_active = 1'b0;
    logic  r_hs = 1'b0;
    addr_t r_addr = '0;
    len_t  r_len = '0;
    int    r_idx = 0;
    int    push_count = 0;
    int    ar_count = 0;
    addr_t exp_r_addr = '0;
    len_t  exp_r_len = '0;
    resp_t last_rresp = '0;

    axi_burst_master uut (.*);

    always #(CLK_HALF) aclk = ~aclk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one LFSR step per returned bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // contents the slave returns for a read of one beat address
    function automatic data_t read_word(input addr_t a);
        return {a ^ 32'h5A5A_A5A5, ~a};
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("CHECK FAILED %s expected 0x%h actual 0x%h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic report_problem(input string what);
        other_errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // AXI slave and user FIFO model, drives on the falling edge and samples 1 ns later
    always @(negedge aclk)
    begin
        if (!slave_live)
        begin
            m_axi_awready    = 1'b0;
            m_axi_wready     = 1'b0;
            m_axi_arready    = 1'b0;
            m_axi_bvalid     = 1'b0;
            m_axi_rvalid     = 1'b0;
            user_r_fifo_full = 1'b0;
        end
        else
        begin
            // effects of the handshakes at the edge just passed
            if (pop_seen && wfifo.size() > 0)
                void'(wfifo.pop_front());
            if (b_hs)
            begin
                m_axi_bvalid = 1'b0;
                b_pending--;
            end
            if (r_hs)
                m_axi_rvalid = 1'b0;

            m_axi_awready    = (random_bits(2) != 32'd0);
            m_axi_wready     = (random_bits(2) != 32'd0);
            m_axi_arready    = (random_bits(2) != 32'd0);
            user_r_fifo_full = (random_bits(2) == 32'd0);  // full about a quarter of the time
            if (!m_axi_bvalid && b_pending > 0 && random_bits(1) != 32'd0)
            begin
                m_axi_bvalid = 1'b1;
                m_axi_bresp  = resp_t'(random_bits(2));
            end
            if (r_active && !m_axi_rvalid && random_bits(2) != 32'd0)
            begin
                m_axi_rvalid = 1'b1;
                m_axi_rdata  = read_word(r_addr + addr_t'(r_idx << 3));
                m_axi_rresp  = resp_t'(random_bits(2));
                m_axi_rlast  = (r_idx == int'(r_len));
            end
        end
        user_w_data     = (wfifo.size() > 0) ? wfifo[0] : '0;
        user_w_fifo_cnt = beats_t'(wfifo.size());

        #1;
        slave_live = aresetn;
        if (slave_live)
        begin
            if (m_axi_awvalid && m_axi_awready)
            begin
                if (exp_aw.size() == 0)
                    report_problem("AW burst issued while none was expected");
                else
                begin
                    aw_want = exp_aw.pop_front();
                    compare("m_axi_awaddr", 64'(aw_want.addr), 64'(m_axi_awaddr));
                    compare("m_axi_awlen", 64'(aw_want.len), 64'(m_axi_awlen));
                    cur_wlen  = aw_want.len;
                    wbeat_idx = 0;
                end
            end
            compare("user_w_data_pop_req", 64'(m_axi_wvalid && m_axi_wready),
                    64'(user_w_data_pop_req));
            pop_seen = user_w_data_pop_req;
            if (user_w_data_pop_req)
                pop_count++;
            if (m_axi_wvalid && m_axi_wready)
            begin
                if (exp_wdata.size() == 0)
                    report_problem("W beat sent while none was expected");
                else
                    compare("m_axi_wdata", exp_wdata.pop_front(), m_axi_wdata);
                compare("m_axi_wstrb", 64'hFF, 64'(m_axi_wstrb));
                compare("m_axi_wlast", 64'(wbeat_idx == int'(cur_wlen)), 64'(m_axi_wlast));
                if (m_axi_wlast)
                    b_pending++;
                wbeat_idx++;
            end
            b_hs = m_axi_bvalid && m_axi_bready;
            if (b_hs)
                last_bresp = m_axi_bresp;

            if (m_axi_arvalid && m_axi_arready)
            begin
                compare("m_axi_araddr", 64'(exp_r_addr), 64'(m_axi_araddr));
                compare("m_axi_arlen", 64'(exp_r_len), 64'(m_axi_arlen));
                ar_count++;
                r_active = 1'b1;
                r_addr   = m_axi_araddr;
                r_len    = m_axi_arlen;
                r_idx    = 0;
            end
            if (user_r_fifo_full)
                compare("m_axi_rready", 64'd0, 64'(m_axi_rready));
            r_hs = m_axi_rvalid && m_axi_rready;
            compare("user_r_data_push_req", 64'(r_hs), 64'(user_r_data_push_req));
            if (user_r_data_push_req)
            begin
                compare("user_r_data", read_word(exp_r_addr + addr_t'(r_idx << 3)), user_r_data);
                push_count++;
            end
            if (r_hs)
            begin
                last_rresp = m_axi_rresp;
                r_idx++;
                if (m_axi_rlast)
                    r_active = 1'b0;
            end
        end
    end

    task automatic run_write;
        int       kind;
        int       total;
        int       fill;
        int       beats_to_page;
        int       pops_before;
        len_t     len;
        addr_t    addr;
        addr_t    page_off;
        cmd_err_t err;
        data_t    word;
        burst_t   first_b;
        burst_t   second_b;
        do @(negedge aclk); while (!user_w_free);
        #2;
        kind  = int'(random_bits(2));  // 0 misaligned, 1 short FIFO, else good
        len   = len_t'(random_bits(6));
        total = int'(len) + 1;
        if (random_bits(1) != 32'd0)
            page_off = addr_t'(PAGE_BYTES) - ((addr_t'(random_bits(5)) + 32'd1) << 3);
        else
            page_off = addr_t'(random_bits(9)) << 3;
        addr = (addr_t'(random_bits(8)) << 12) | page_off;
        if (kind == 0)
            addr[2:0] = 3'(random_bits(2)) + 3'd1;
        fill = (kind == 1) ? int'(random_bits(6)) % total : total;

        err = '0;
        if (addr[2:0] != 3'd0)
            err = err | ERR_MISALIGN;
        if (fill < total)
            err = err | ERR_NODATA;
        for (int k = 0; k < fill; k++)
        begin
            word[63:32] = random_bits(32);
            word[31:0]  = random_bits(32);
            wfifo.push_back(word);
            if (err == '0)
                exp_wdata.push_back(word);
        end
        if (err == '0)
        begin
            beats_to_page = (PAGE_BYTES - int'(page_off)) / BEAT_BYTES;
            first_b.addr  = addr;
            first_b.len   = len;
            if (total > beats_to_page)
            begin
                first_b.len   = len_t'(beats_to_page - 1);
                second_b.addr = addr - page_off + addr_t'(PAGE_BYTES);
                second_b.len  = len_t'(total - beats_to_page - 1);
            end
            exp_aw.push_back(first_b);
            if (total > beats_to_page)
                exp_aw.push_back(second_b);
        end
        pops_before = pop_count;

        @(negedge aclk);
        user_w_start = 1'b1;
        user_w_addr  = addr;
        user_w_len   = len;
        @(negedge aclk);
        user_w_start = 1'b0;
        do @(negedge aclk); while (!user_w_free);

        compare("user_w_cmd_error", 64'(err), 64'(user_w_cmd_error));
        compare("user_w_status", (err == '0) ? 64'(last_bresp) : 64'd0, 64'(user_w_status));
        compare("user_w_data_pop_req count", 64'((err == '0) ? total : 0),
                64'(pop_count - pops_before));
        if (exp_aw.size() != 0)
            report_problem("expected AW bursts were never issued");
        if (exp_wdata.size() != 0)
            report_problem("expected W beats were never sent");
        #2;
        wfifo.delete();  // leftovers of a rejected command
        exp_aw.delete();
        exp_wdata.delete();
    endtask

    task automatic run_read;
        addr_t addr;
        len_t  len;
        int    pushes_before;
        int    ars_before;
        do @(negedge aclk); while (!user_r_free);
        #2;
        addr          = addr_t'(random_bits(20)) << 3;
        len           = len_t'(random_bits(5));
        exp_r_addr    = addr;
        exp_r_len     = len;
        pushes_before = push_count;
        ars_before    = ar_count;

        @(negedge aclk);
        user_r_start = 1'b1;
        user_r_addr  = addr;
        user_r_len   = len;
        @(negedge aclk);
        user_r_start = 1'b0;
        do @(negedge aclk); while (!user_r_free);

        compare("user_r_data_push_req count", 64'(int'(len) + 1), 64'(push_count - pushes_before));
        compare("m_axi_arvalid bursts", 64'd1, 64'(ar_count - ars_before));
        compare("user_r_status", 64'(last_rresp), 64'(user_r_status));
    endtask

    initial
    begin
        aresetn      = 1'b0;
        user_w_start = 1'b0;
        user_w_addr  = '0;
        user_w_len   = '0;
        user_w_strb  = 8'hFF;  // full-width beats only
        user_r_start = 1'b0;
        user_r_addr  = '0;
        user_r_len   = '0;
        repeat (2) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        compare("m_axi_awvalid", 64'd0, 64'(m_axi_awvalid));
        compare("m_axi_wvalid", 64'd0, 64'(m_axi_wvalid));
        compare("m_axi_bready", 64'd0, 64'(m_axi_bready));
        compare("m_axi_arvalid", 64'd0, 64'(m_axi_arvalid));
        compare("m_axi_rready", 64'd0, 64'(m_axi_rready));
        compare("user_w_data_pop_req", 64'd0, 64'(user_w_data_pop_req));
        compare("user_r_data_push_req", 64'd0, 64'(user_r_data_push_req));
        compare("user_w_free", 64'd1, 64'(user_w_free));
        compare("user_r_free", 64'd1, 64'(user_r_free));

        for (int i = 0; i < N_CMDS; i++)
        begin
            run_write();
            run_read();
        end

        $display("value mismatches: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("ERROR: run did not complete within %0d ns", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/axi_burst_master_props.sv
// AXI channel stability and WLAST assertions, bound into the burst master top
`timescale 1ns/1ps
`default_nettype none

module axi_burst_master_props
    import burst_pkg::*;
(
    input  wire      aclk,
    input  wire      aresetn,
    input  addr_t    m_axi_awaddr,
    input  len_t     m_axi_awlen,
    input  wire      m_axi_awvalid,
    input  wire      m_axi_awready,
    input  data_t    m_axi_wdata,
    input  wire      m_axi_wvalid,
    input  wire      m_axi_wready,
    input  wire      m_axi_wlast,
    input  cmd_err_t cmd_err
);

    len_t w_cnt;  // W beats accepted since the last AW handshake

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            w_cnt <= '0;
        else if (m_axi_awvalid && m_axi_awready)
            w_cnt <= '0;
        else if (m_axi_wvalid && m_axi_wready)
            w_cnt <= w_cnt + len_t'(1);
    end

    // AW held under back-pressure
    assert property (@(posedge aclk) disable iff (!aresetn)
        m_axi_awvalid && !m_axi_awready |=>
            m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen))
    else $error("AW request changed while stalled");

    assert property (@(posedge aclk) disable iff (!aresetn)
        m_axi_wvalid && !m_axi_wready |=>
            m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wlast))
    else $error("W beat changed while stalled");

    // WLAST only with WVALID, and exactly on the beat that matches AWLEN
    assert property (@(posedge aclk) disable iff (!aresetn)
        (m_axi_wvalid || m_axi_wlast) |->
            m_axi_wvalid && (m_axi_wlast == (w_cnt == m_axi_awlen)))
    else $error("WLAST on the wrong beat or without WVALID");

    // a rejected command never reaches the AW channel
    assert property (@(posedge aclk) disable iff (!aresetn)
        m_axi_awvalid |-> (cmd_err == cmd_err_t'(0)))
    else $error("AWVALID for a rejected command");

endmodule

bind axi_burst_master axi_burst_master_props u_props (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awlen   (m_axi_awlen),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_wlast   (m_axi_wlast),
    .cmd_err       (cmd_err)
);

`default_nettype wire

// File: logic/axi_burst_master.sv
// AXI4 burst master top, joins the write planner, write FSM, beat counter and read channel
`timescale 1ns/1ps
`default_nettype none

module axi_burst_master
    import burst_pkg::*;
(
    input  wire      aclk,
    input  wire      aresetn,
    // AW
    output addr_t    m_axi_awaddr,
    output len_t     m_axi_awlen,
    output logic     m_axi_awvalid,
    input  wire      m_axi_awready,
    // W
    output data_t    m_axi_wdata,
    output strb_t    m_axi_wstrb,
    output logic     m_axi_wvalid,
    output logic     m_axi_wlast,
    input  wire      m_axi_wready,
    // B
    input  resp_t    m_axi_bresp,
    input  wire      m_axi_bvalid,
    output logic     m_axi_bready,
    // AR
    output addr_t    m_axi_araddr,
    output len_t     m_axi_arlen,
    output logic     m_axi_arvalid,
    input  wire      m_axi_arready,
    // R
    input  data_t    m_axi_rdata,
    input  resp_t    m_axi_rresp,
    input  wire      m_axi_rvalid,
    input  wire      m_axi_rlast,
    output logic     m_axi_rready,
    // user write side
    input  wire      user_w_start,
    input  addr_t    user_w_addr,
    input  len_t     user_w_len,
    input  data_t    user_w_data,
    input  strb_t    user_w_strb,
    input  beats_t   user_w_fifo_cnt,
    output logic     user_w_data_pop_req,
    output logic     user_w_free,
    output resp_t    user_w_status,
    output cmd_err_t user_w_cmd_error,
    // user read side
    input  wire      user_r_start,
    input  addr_t    user_r_addr,
    input  len_t     user_r_len,
    input  wire      user_r_fifo_full,
    output data_t    user_r_data,
    output logic     user_r_data_push_req,
    output logic     user_r_free,
    output resp_t    user_r_status
);

    logic     cmd_valid;
    logic     split_pending;
    burst_t   burst;
    cmd_err_t cmd_err;
    logic     burst_done;
    logic     cmd_reject;
    logic     burst_start;
    logic     beat_fire;
    logic     last_beat;

    write_cmd_planner u_write_planner (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .user_w_start    (user_w_start),
        .user_w_addr     (user_w_addr),
        .user_w_len      (user_w_len),
        .user_w_fifo_cnt (user_w_fifo_cnt),
        .burst_done      (burst_done),
        .cmd_reject      (cmd_reject),
        .cmd_valid       (cmd_valid),
        .split_pending   (split_pending),
        .burst           (burst),
        .cmd_err         (cmd_err)
    );

    write_ctrl_fsm u_write_fsm (
        .aclk                (aclk),
        .aresetn             (aresetn),
        .cmd_valid           (cmd_valid),
        .split_pending       (split_pending),
        .cmd_err             (cmd_err),
        .burst               (burst),
        .last_beat           (last_beat),
        .m_axi_awready       (m_axi_awready),
        .m_axi_wready        (m_axi_wready),
        .m_axi_bvalid        (m_axi_bvalid),
        .m_axi_bresp         (m_axi_bresp),
        .user_w_data         (user_w_data),
        .user_w_strb         (user_w_strb),
        .m_axi_awaddr        (m_axi_awaddr),
        .m_axi_awlen         (m_axi_awlen),
        .m_axi_awvalid       (m_axi_awvalid),
        .m_axi_wdata         (m_axi_wdata),
        .m_axi_wstrb         (m_axi_wstrb),
        .m_axi_wvalid        (m_axi_wvalid),
        .m_axi_wlast         (m_axi_wlast),
        .m_axi_bready        (m_axi_bready),
        .user_w_data_pop_req (user_w_data_pop_req),
        .user_w_free         (user_w_free),
        .user_w_status       (user_w_status),
        .user_w_cmd_error    (user_w_cmd_error),
        .burst_start         (burst_start),
        .beat_fire           (beat_fire),
        .burst_done          (burst_done),
        .cmd_reject          (cmd_reject)
    );

    beat_counter u_beat_counter (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .burst_start (burst_start),
        .beat_fire   (beat_fire),
        .burst_len   (burst.len),
        .last_beat   (last_beat)
    );

    read_channel u_read_channel (
        .aclk                 (aclk),
        .aresetn              (aresetn),
        .user_r_start         (user_r_start),
        .user_r_addr          (user_r_addr),
        .user_r_len           (user_r_len),
        .user_r_fifo_full     (user_r_fifo_full),
        .m_axi_arready        (m_axi_arready),
        .m_axi_rdata          (m_axi_rdata),
        .m_axi_rresp          (m_axi_rresp),
        .m_axi_rvalid         (m_axi_rvalid),
        .m_axi_rlast          (m_axi_rlast),
        .m_axi_araddr         (m_axi_araddr),
        .m_axi_arlen          (m_axi_arlen),
        .m_axi_arvalid        (m_axi_arvalid),
        .m_axi_rready         (m_axi_rready),
        .user_r_data          (user_r_data),
        .user_r_data_push_req (user_r_data_push_req),
        .user_r_free          (user_r_free),
        .user_r_status        (user_r_status)
    );

endmodule

`default_nettype wire

// File: logic/read_channel.sv
// read side, one AR burst per command with R beats forwarded into the user FIFO
`timescale 1ns/1ps
`default_nettype none

module read_channel
    import burst_pkg::*;
(
    input  wire   aclk,
    input  wire   aresetn,
    input  wire   user_r_start,
    input  addr_t user_r_addr,
    input  len_t  user_r_len,
    input  wire   user_r_fifo_full,
    input  wire   m_axi_arready,
    input  data_t m_axi_rdata,
    input  resp_t m_axi_rresp,
    input  wire   m_axi_rvalid,
    input  wire   m_axi_rlast,
    output addr_t m_axi_araddr,
    output len_t  m_axi_arlen,
    output logic  m_axi_arvalid,
    output logic  m_axi_rready,
    output data_t user_r_data,
    output logic  user_r_data_push_req,
    output logic  user_r_free,
    output resp_t user_r_status
);

    read_state_t state_q;
    read_state_t state_d;
    burst_t      cmd_q;
    resp_t       status_q;
    logic        beat_ok;

    assign beat_ok = m_axi_rvalid && m_axi_rready;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            R_IDLE:
                if (user_r_start)
                    state_d = R_ADDR;
            R_ADDR:
                if (m_axi_arready)
                    state_d = R_DATA;
            R_DATA:
                if (beat_ok && m_axi_rlast)
                    state_d = R_IDLE;
            default:
                state_d = R_IDLE;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            state_q <= R_IDLE;
        else
            state_q <= state_d;
    end

    // command register, loaded only while idle
    always_ff @(posedge aclk)
    begin
        if (state_q == R_IDLE && user_r_start)
        begin
            cmd_q.addr <= user_r_addr;
            cmd_q.len  <= user_r_len;
        end
    end

    // keeps the latest accepted RRESP
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            status_q <= '0;
        else if (beat_ok)
            status_q <= m_axi_rresp;
    end

    assign m_axi_araddr  = cmd_q.addr;
    assign m_axi_arlen   = cmd_q.len;
    assign m_axi_arvalid = (state_q == R_ADDR);
    assign m_axi_rready  = (state_q == R_DATA) && !user_r_fifo_full; // stall while FIFO full

    assign user_r_data          = m_axi_rdata;
    assign user_r_data_push_req = beat_ok;
    assign user_r_free          = (state_q == R_IDLE);
    assign user_r_status        = status_q;

endmodule

`default_nettype wire

// File: logic/write_ctrl_fsm.sv
// write FSM driving AW, W and B, with the write status and command error registers
`timescale 1ns/1ps
`default_nettype none

module write_ctrl_fsm
    import burst_pkg::*;
(
    input  wire      aclk,
    input  wire      aresetn,
    input  wire      cmd_valid,
    input  wire      split_pending,
    input  cmd_err_t cmd_err,
    input  burst_t   burst,
    input  wire      last_beat,
    input  wire      m_axi_awready,
    input  wire      m_axi_wready,
    input  wire      m_axi_bvalid,
    input  resp_t    m_axi_bresp,
    input  data_t    user_w_data,
    input  strb_t    user_w_strb,
    output addr_t    m_axi_awaddr,
    output len_t     m_axi_awlen,
    output logic     m_axi_awvalid,
    output data_t    m_axi_wdata,
    output strb_t    m_axi_wstrb,
    output logic     m_axi_wvalid,
    output logic     m_axi_wlast,
    output logic     m_axi_bready,
    output logic     user_w_data_pop_req,
    output logic     user_w_free,
    output resp_t    user_w_status,
    output cmd_err_t user_w_cmd_error,
    output logic     burst_start,
    output logic     beat_fire,
    output logic     burst_done,
    output logic     cmd_reject
);

    write_state_t state_q;
    write_state_t state_d;
    resp_t        status_q;
    cmd_err_t     error_q;
    logic         new_cmd;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            W_IDLE:
                if (cmd_valid)
                    state_d = W_CHECK;
            W_CHECK:
                state_d = (|cmd_err) ? W_IDLE : W_ADDR;
            W_ADDR:
                if (m_axi_awready)
                    state_d = W_DATA;
            W_DATA:
                if (m_axi_wready && last_beat)
                    state_d = W_RESP;
            W_RESP:
                if (m_axi_bvalid)
                    state_d = split_pending ? W_ADDR : W_IDLE; // second half reuses AW
            default:
                state_d = W_IDLE;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            state_q <= W_IDLE;
        else
            state_q <= state_d;
    end

    assign new_cmd     = (state_q == W_IDLE) && cmd_valid;
    assign burst_start = (state_d == W_ADDR) && (state_q != W_ADDR);
    assign beat_fire   = (state_q == W_DATA) && m_axi_wready;  // WVALID is high all of W_DATA
    assign burst_done  = (state_q == W_RESP) && m_axi_bvalid;
    assign cmd_reject  = (state_q == W_CHECK) && (|cmd_err);

    // channel outputs, AW fields hold while the burst is current
    assign m_axi_awaddr  = burst.addr;
    assign m_axi_awlen   = burst.len;
    assign m_axi_awvalid = (state_q == W_ADDR);

    assign m_axi_wdata  = user_w_data;  // FIFO head
    assign m_axi_wstrb  = user_w_strb;
    assign m_axi_wvalid = (state_q == W_DATA);
    assign m_axi_wlast  = (state_q == W_DATA) && last_beat;
    assign m_axi_bready = (state_q == W_RESP);

    assign user_w_data_pop_req = beat_fire;
    assign user_w_free         = (state_q == W_IDLE) && !cmd_valid;

    // status and error registers, cleared as a fresh command comes in
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            status_q <= '0;
            error_q  <= '0;
        end
        else if (new_cmd)
        begin
            status_q <= '0;
            error_q  <= '0;
        end
        else
        begin
            if (burst_done)
                status_q <= m_axi_bresp; // last burst's response wins
            if (cmd_reject)
                error_q <= cmd_err;
        end
    end

    assign user_w_status    = status_q;
    assign user_w_cmd_error = error_q;

endmodule

`default_nettype wire

// File: logic/write_cmd_planner.sv
// write command register, checks the command and splits a burst at the page boundary
`timescale 1ns/1ps
`default_nettype none

module write_cmd_planner
    import burst_pkg::*;
(
    input  wire      aclk,
    input  wire      aresetn,
    input  wire      user_w_start,
    input  addr_t    user_w_addr,
    input  len_t     user_w_len,
    input  beats_t   user_w_fifo_cnt,
    input  wire      burst_done,
    input  wire      cmd_reject,
    output logic     cmd_valid,
    output logic     split_pending,
    output burst_t   burst,
    output cmd_err_t cmd_err
);

    logic     cmd_valid_q;
    logic     split_q;
    burst_t   burst_q;    // burst currently on the bus
    burst_t   second_q;   // remainder after the page boundary
    cmd_err_t err_q;

    beats_t   total_beats;
    addr_t    page_off;
    addr_t    bytes_to_page;
    beats_t   beats_to_page;
    logic     crosses;
    logic     misalign;
    logic     nodata;
    burst_t   first_plan;
    burst_t   second_plan;
    cmd_err_t new_err;

    // plan both halves straight from the command inputs
    always_comb
    begin
        total_beats   = beats_t'(user_w_len) + beats_t'(1);
        page_off      = user_w_addr & addr_t'(PAGE_BYTES - 1);
        bytes_to_page = addr_t'(PAGE_BYTES) - page_off;
        beats_to_page = beats_t'(bytes_to_page >> BEAT_BYTES_LOG); // at most one page
        crosses       = total_beats > beats_to_page;

        misalign = |user_w_addr[BEAT_BYTES_LOG-1:0];
        nodata   = user_w_fifo_cnt < total_beats; // whole burst must already be queued
        new_err  = (misalign ? ERR_MISALIGN : cmd_err_t'(0)) |
                   (nodata ? ERR_NODATA : cmd_err_t'(0));

        first_plan.addr = user_w_addr;
        first_plan.len  = crosses ? len_t'(beats_to_page - beats_t'(1)) : user_w_len;

        // second half starts at the next page base
        second_plan.addr = user_w_addr + bytes_to_page;
        second_plan.len  = len_t'(total_beats - beats_to_page - beats_t'(1));
    end

    // control flags
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            cmd_valid_q <= 1'b0;
            split_q     <= 1'b0;
        end
        else if (!cmd_valid_q)
        begin
            if (user_w_start)
            begin
                cmd_valid_q <= 1'b1;
                split_q     <= crosses;
            end
        end
        else if (cmd_reject)
        begin
            cmd_valid_q <= 1'b0;
            split_q     <= 1'b0;
        end
        else if (burst_done)
        begin
            if (split_q)
                split_q <= 1'b0;     // move on to the remainder
            else
                cmd_valid_q <= 1'b0; // final response, command done
        end
    end

    // command payload
    always_ff @(posedge aclk)
    begin
        if (!cmd_valid_q && user_w_start)
        begin
            burst_q  <= first_plan;
            second_q <= second_plan;
            err_q    <= new_err;
        end
        else if (cmd_valid_q && burst_done && split_q)
        begin
            burst_q <= second_q;
        end
    end

    assign cmd_valid     = cmd_valid_q;
    assign split_pending = split_q;
    assign burst         = burst_q;
    assign cmd_err       = err_q;

endmodule

`default_nettype wire

// File: logic/beat_counter.sv
// counts accepted W beats and flags the last beat of the current burst
`timescale 1ns/1ps
`default_nettype none

module beat_counter
    import burst_pkg::*;
(
    input  wire  aclk,
    input  wire  aresetn,
    input  wire  burst_start,
    input  wire  beat_fire,
    input  len_t burst_len,
    output logic last_beat
);

    len_t count_q;  // beats already accepted in this burst

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            count_q <= '0;
        else if (burst_start)
            count_q <= '0;
        else if (beat_fire)
            count_q <= count_q + len_t'(1);
    end

    // len is beats minus one, so equality marks the final beat
    assign last_beat = (count_q == burst_len);

endmodule

`default_nettype wire

// File: logic/burst_pkg.sv
// shared widths, page geometry, error codes and state types for the AXI4 burst master
`default_nettype none

package burst_pkg;

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 64;
    localparam int BEAT_BYTES     = 8;    // full-width beats only
    localparam int BEAT_BYTES_LOG = 3;
    localparam int PAGE_BYTES     = 4096; // no burst may cross this
    localparam int LEN_W          = 8;    // AXI4 length field
    localparam int RESP_W         = 2;

    typedef logic [ADDR_W-1:0]     addr_t;   // byte address
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [BEAT_BYTES-1:0] strb_t;
    typedef logic [LEN_W-1:0]      len_t;    // beats minus one
    typedef logic [9:0]            beats_t;  // beat count, up to one page (512)
    typedef logic [RESP_W-1:0]     resp_t;

    // bit 0 misaligned start, bit 1 not enough data in the user FIFO
    typedef logic [1:0] cmd_err_t;

    localparam cmd_err_t ERR_MISALIGN = 2'b01;
    localparam cmd_err_t ERR_NODATA   = 2'b10;

    // one AXI burst request
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } burst_t;

    typedef enum logic [2:0] {
        W_IDLE,
        W_CHECK,
        W_ADDR,
        W_DATA,
        W_RESP
    } write_state_t;

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_DATA
    } read_state_t;

endpackage

`default_nettype wire
